// File: source/rob_pkg.sv
/*
 * rob_pkg
 * shared widths, depths and the entry kind for the retirement back end
 * (rename map, reorder buffer, retire unit)
 */

package rob_pkg;

    ////////////////////////////////////////////////////////////
    // register file geometry
    ////////////////////////////////////////////////////////////
    localparam int arch_bits = 5;   // architectural register number
    localparam int phys_bits = 6;   // physical register number
    localparam int num_arch  = 32;
    localparam int num_phys  = 64;

    ////////////////////////////////////////////////////////////
    // reorder buffer geometry
    ////////////////////////////////////////////////////////////
    localparam int rob_depth = 16;
    localparam int tag_bits  = 4;   // rob index, also the completion tag
    localparam int data_bits = 32;  // result values and pc

    // what an entry does at retirement
    typedef enum logic {
        kind_alu   = 1'b0,  // writes the arf, frees its old phys reg
        kind_store = 1'b1   // only flagged at commit
    } entry_kind_t;

endpackage

// File: source/rename_map.sv
/*
 * rename_map
 * speculative map from architectural to physical registers, plus the
 * circular FIFO free list. a non-store dispatch pops one register and
 * remaps its destination; retired registers come back in slot order
 */

`timescale 1ns/100ps

module rename_map (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          dispatch_valid,
    input  logic                          dispatch_is_store,
    input  logic [rob_pkg::arch_bits-1:0] dispatch_arch_dest,
    input  logic                          accept,
    input  logic                          free_valid_0,
    input  logic                          free_valid_1,
    input  logic [rob_pkg::phys_bits-1:0] free_phys_0,
    input  logic [rob_pkg::phys_bits-1:0] free_phys_1,
    output logic [rob_pkg::phys_bits-1:0] alloc_phys,
    output logic [rob_pkg::phys_bits-1:0] old_phys
);

    logic [rob_pkg::phys_bits-1:0] map_table [rob_pkg::num_arch];
    logic [rob_pkg::phys_bits-1:0] free_list [rob_pkg::num_phys];
    logic [rob_pkg::phys_bits-1:0] fl_head;   // wraps at num_phys
    logic [rob_pkg::phys_bits-1:0] fl_tail;
    logic                          alloc_en;
    logic [rob_pkg::phys_bits-1:0] push_1_idx;

    assign alloc_en = dispatch_valid && accept && !dispatch_is_store;

    // head of the fifo and the current mapping, seen in the dispatch cycle
    assign alloc_phys = free_list[fl_head];
    assign old_phys   = map_table[dispatch_arch_dest];

    // slot 1 lands behind slot 0 only when slot 0 also pushes
    assign push_1_idx = free_valid_0 ? fl_tail + 1'b1 : fl_tail;

    ////////////////////////////////////////////////////////////
    // map table
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int r = 0; r < rob_pkg::num_arch; r++) begin
                map_table[r] <= rob_pkg::phys_bits'(r);   // identity map
            end
        end else if (alloc_en) begin
            map_table[dispatch_arch_dest] <= alloc_phys;
        end
    end

    ////////////////////////////////////////////////////////////
    // free list
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            // slots 0..31 get regs 32..63, the upper half is never read yet
            for (int i = 0; i < rob_pkg::num_phys; i++) begin
                free_list[i] <= rob_pkg::phys_bits'(i + rob_pkg::num_arch);
            end
            fl_head <= '0;
            fl_tail <= rob_pkg::phys_bits'(rob_pkg::num_arch);
        end else begin
            if (alloc_en) begin
                fl_head <= fl_head + 1'b1;
            end
            if (free_valid_0) begin
                free_list[fl_tail] <= free_phys_0;
            end
            if (free_valid_1) begin
                free_list[push_1_idx] <= free_phys_1;
            end
            case ({free_valid_1, free_valid_0})
                2'b01, 2'b10: fl_tail <= fl_tail + 1'b1;
                2'b11:        fl_tail <= fl_tail + 2'd2;
                default:      fl_tail <= fl_tail;
            endcase
        end
    end

endmodule

// File: source/reorder_buffer.sv
/*
 * reorder_buffer
 * 16 entry circular ROB. allocates in program order, marks entries
 * complete by tag from two completion ports, and retires up to the two
 * oldest complete entries per cycle. stall is raised while it is full
 */

`timescale 1ns/100ps

module reorder_buffer (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          dispatch_valid,
    input  logic                          dispatch_is_store,
    input  logic [rob_pkg::arch_bits-1:0] dispatch_arch_dest,
    input  logic [rob_pkg::data_bits-1:0] dispatch_pc,
    input  logic [rob_pkg::phys_bits-1:0] alloc_phys,
    input  logic [rob_pkg::phys_bits-1:0] old_phys,
    input  logic                          complete_valid_0,
    input  logic                          complete_valid_1,
    input  logic [rob_pkg::tag_bits-1:0]  complete_tag_0,
    input  logic [rob_pkg::tag_bits-1:0]  complete_tag_1,
    input  logic [rob_pkg::data_bits-1:0] complete_data_0,
    input  logic [rob_pkg::data_bits-1:0] complete_data_1,
    output logic                          accept,
    output logic                          stall,
    output logic [rob_pkg::tag_bits-1:0]  dispatch_tag,
    output logic                          retire_valid_0,
    output logic                          retire_valid_1,
    output logic [rob_pkg::arch_bits-1:0] retire_arch_0,
    output logic [rob_pkg::arch_bits-1:0] retire_arch_1,
    output logic [rob_pkg::phys_bits-1:0] retire_old_phys_0,
    output logic [rob_pkg::phys_bits-1:0] retire_old_phys_1,
    output logic [rob_pkg::data_bits-1:0] retire_value_0,
    output logic [rob_pkg::data_bits-1:0] retire_value_1,
    output logic [rob_pkg::data_bits-1:0] retire_pc_0,
    output logic [rob_pkg::data_bits-1:0] retire_pc_1,
    output rob_pkg::entry_kind_t          retire_kind_0,
    output rob_pkg::entry_kind_t          retire_kind_1
);

    // entry state, control bits carry reset
    logic                          ent_valid    [rob_pkg::rob_depth];
    logic                          ent_complete [rob_pkg::rob_depth];
    // entry payload
    rob_pkg::entry_kind_t          ent_kind     [rob_pkg::rob_depth];
    logic [rob_pkg::arch_bits-1:0] ent_arch     [rob_pkg::rob_depth];
    logic [rob_pkg::phys_bits-1:0] ent_phys     [rob_pkg::rob_depth];
    logic [rob_pkg::phys_bits-1:0] ent_old_phys [rob_pkg::rob_depth];
    logic [rob_pkg::data_bits-1:0] ent_value    [rob_pkg::rob_depth];
    logic [rob_pkg::data_bits-1:0] ent_pc       [rob_pkg::rob_depth];

    logic [rob_pkg::tag_bits-1:0]  head;
    logic [rob_pkg::tag_bits-1:0]  head_nxt;
    logic [rob_pkg::tag_bits-1:0]  tail;
    logic [rob_pkg::tag_bits:0]    count;      // 0..16
    logic                          full;
    logic [1:0]                    n_retire;

    ////////////////////////////////////////////////////////////
    // occupancy and dispatch
    ////////////////////////////////////////////////////////////
    assign full         = (count == (rob_pkg::tag_bits + 1)'(rob_pkg::rob_depth));
    assign stall        = full;
    assign accept       = dispatch_valid && !full;
    assign dispatch_tag = tail;

    ////////////////////////////////////////////////////////////
    // in-order retirement, head first then head+1
    ////////////////////////////////////////////////////////////
    assign head_nxt       = head + 1'b1;
    assign retire_valid_0 = ent_valid[head] && ent_complete[head];
    assign retire_valid_1 = retire_valid_0 && ent_valid[head_nxt] && ent_complete[head_nxt];
    assign n_retire       = {1'b0, retire_valid_0} + {1'b0, retire_valid_1};

    assign retire_arch_0     = ent_arch[head];
    assign retire_old_phys_0 = ent_old_phys[head];
    assign retire_value_0    = ent_value[head];
    assign retire_pc_0       = ent_pc[head];
    assign retire_kind_0     = ent_kind[head];

    assign retire_arch_1     = ent_arch[head_nxt];
    assign retire_old_phys_1 = ent_old_phys[head_nxt];
    assign retire_value_1    = ent_value[head_nxt];
    assign retire_pc_1       = ent_pc[head_nxt];
    assign retire_kind_1     = ent_kind[head_nxt];

    // pointers, count and per-entry flags
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_pkg::rob_depth; i++) begin
                ent_valid[i]    <= 1'b0;
                ent_complete[i] <= 1'b0;
            end
        end else begin
            if (retire_valid_0) ent_valid[head]     <= 1'b0;
            if (retire_valid_1) ent_valid[head_nxt] <= 1'b0;

            if (complete_valid_0) ent_complete[complete_tag_0] <= 1'b1;
            if (complete_valid_1) ent_complete[complete_tag_1] <= 1'b1;

            if (accept) begin
                ent_valid[tail]    <= 1'b1;
                ent_complete[tail] <= 1'b0;   // tail slot is never the one completing
                tail               <= tail + 1'b1;
            end

            head  <= head + rob_pkg::tag_bits'(n_retire);
            count <= count + (rob_pkg::tag_bits + 1)'(accept)
                           - (rob_pkg::tag_bits + 1)'(n_retire);
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (accept) begin
            ent_kind[tail]     <= dispatch_is_store ? rob_pkg::kind_store : rob_pkg::kind_alu;
            ent_arch[tail]     <= dispatch_arch_dest;
            ent_phys[tail]     <= alloc_phys;   // don't care for stores
            ent_old_phys[tail] <= old_phys;
            ent_pc[tail]       <= dispatch_pc;
        end
        if (complete_valid_0) ent_value[complete_tag_0] <= complete_data_0;
        if (complete_valid_1) ent_value[complete_tag_1] <= complete_data_1;
    end

endmodule

// File: source/retire_unit.sv
/*
 * retire_unit
 * architectural register file write for retiring ALU entries, registered
 * commit report for both slots, and the return of replaced physical
 * registers to the free list
 */

`timescale 1ns/100ps

module retire_unit (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          retire_valid_0,
    input  logic                          retire_valid_1,
    input  logic [rob_pkg::arch_bits-1:0] retire_arch_0,
    input  logic [rob_pkg::arch_bits-1:0] retire_arch_1,
    input  logic [rob_pkg::phys_bits-1:0] retire_old_phys_0,
    input  logic [rob_pkg::phys_bits-1:0] retire_old_phys_1,
    input  logic [rob_pkg::data_bits-1:0] retire_value_0,
    input  logic [rob_pkg::data_bits-1:0] retire_value_1,
    input  logic [rob_pkg::data_bits-1:0] retire_pc_0,
    input  logic [rob_pkg::data_bits-1:0] retire_pc_1,
    input  rob_pkg::entry_kind_t          retire_kind_0,
    input  rob_pkg::entry_kind_t          retire_kind_1,
    output logic                          free_valid_0,
    output logic                          free_valid_1,
    output logic [rob_pkg::phys_bits-1:0] free_phys_0,
    output logic [rob_pkg::phys_bits-1:0] free_phys_1,
    output logic                          commit_valid_0,
    output logic                          commit_valid_1,
    output logic [rob_pkg::arch_bits-1:0] commit_arch_0,
    output logic [rob_pkg::arch_bits-1:0] commit_arch_1,
    output logic [rob_pkg::data_bits-1:0] commit_value_0,
    output logic [rob_pkg::data_bits-1:0] commit_value_1,
    output logic [rob_pkg::data_bits-1:0] commit_pc_0,
    output logic [rob_pkg::data_bits-1:0] commit_pc_1,
    output logic                          commit_is_store_0,
    output logic                          commit_is_store_1
);

    logic [rob_pkg::data_bits-1:0] arf [rob_pkg::num_arch];

    // only ALU retirements give a register back
    assign free_valid_0 = retire_valid_0 && (retire_kind_0 == rob_pkg::kind_alu);
    assign free_valid_1 = retire_valid_1 && (retire_kind_1 == rob_pkg::kind_alu);
    assign free_phys_0  = retire_old_phys_0;
    assign free_phys_1  = retire_old_phys_1;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int r = 0; r < rob_pkg::num_arch; r++) begin
                arf[r] <= '0;
            end
            commit_valid_0 <= 1'b0;
            commit_valid_1 <= 1'b0;
        end else begin
            if (free_valid_0) arf[retire_arch_0] <= retire_value_0;
            if (free_valid_1) arf[retire_arch_1] <= retire_value_1;   // younger wins
            commit_valid_0 <= retire_valid_0;
            commit_valid_1 <= retire_valid_1;
        end
    end

    ////////////////////////////////////////////////////////////
    // commit report payload
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        commit_arch_0     <= retire_arch_0;
        commit_arch_1     <= retire_arch_1;
        commit_value_0    <= retire_value_0;
        commit_value_1    <= retire_value_1;
        commit_pc_0       <= retire_pc_0;
        commit_pc_1       <= retire_pc_1;
        commit_is_store_0 <= (retire_kind_0 == rob_pkg::kind_store);
        commit_is_store_1 <= (retire_kind_1 == rob_pkg::kind_store);
    end

endmodule

// File: source/rob_top.sv
/*
 * rob_top
 * retirement back end: rename map in front, reorder buffer in the
 * middle, retire unit at the commit side
 */

`timescale 1ns/100ps

module rob_top (
    input  logic                          clk,
    input  logic                          rstn,
    // dispatch
    input  logic                          dispatch_valid,
    input  logic [rob_pkg::arch_bits-1:0] dispatch_arch_dest,
    input  logic [rob_pkg::data_bits-1:0] dispatch_pc,
    input  logic                          dispatch_is_store,
    output logic [rob_pkg::tag_bits-1:0]  dispatch_tag,
    output logic [rob_pkg::phys_bits-1:0] dispatch_phys_dest,
    output logic                          stall,
    // completion
    input  logic                          complete_valid_0,
    input  logic                          complete_valid_1,
    input  logic [rob_pkg::tag_bits-1:0]  complete_tag_0,
    input  logic [rob_pkg::tag_bits-1:0]  complete_tag_1,
    input  logic [rob_pkg::data_bits-1:0] complete_data_0,
    input  logic [rob_pkg::data_bits-1:0] complete_data_1,
    // commit
    output logic                          commit_valid_0,
    output logic                          commit_valid_1,
    output logic [rob_pkg::arch_bits-1:0] commit_arch_0,
    output logic [rob_pkg::arch_bits-1:0] commit_arch_1,
    output logic [rob_pkg::data_bits-1:0] commit_value_0,
    output logic [rob_pkg::data_bits-1:0] commit_value_1,
    output logic [rob_pkg::data_bits-1:0] commit_pc_0,
    output logic [rob_pkg::data_bits-1:0] commit_pc_1,
    output logic                          commit_is_store_0,
    output logic                          commit_is_store_1
);

    logic                          accept;
    logic [rob_pkg::phys_bits-1:0] alloc_phys, old_phys;
    logic                          free_valid_0, free_valid_1;
    logic [rob_pkg::phys_bits-1:0] free_phys_0, free_phys_1;
    logic                          retire_valid_0, retire_valid_1;
    logic [rob_pkg::arch_bits-1:0] retire_arch_0, retire_arch_1;
    logic [rob_pkg::phys_bits-1:0] retire_old_phys_0, retire_old_phys_1;
    logic [rob_pkg::data_bits-1:0] retire_value_0, retire_value_1;
    logic [rob_pkg::data_bits-1:0] retire_pc_0, retire_pc_1;
    rob_pkg::entry_kind_t          retire_kind_0, retire_kind_1;

    assign dispatch_phys_dest = alloc_phys;   // head of the free list

    // all connections match by name
    rename_map     u_rename  (.*);
    reorder_buffer u_rob     (.*);
    retire_unit    u_retire  (.*);

endmodule

// File: testbench/rob_checker.sv
/*
 * rob_checker
 * watches the commit, stall and dispatch outputs of the retirement back end
 * and compares them with the expected stream that the testbench sets up
 */

`timescale 1ns/100ps

module rob_checker (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          dispatch_valid,
    input  logic [rob_pkg::tag_bits-1:0]  dispatch_tag,
    input  logic [rob_pkg::phys_bits-1:0] dispatch_phys_dest,
    input  logic                          stall,
    input  logic                          commit_valid_0,
    input  logic                          commit_valid_1,
    input  logic [rob_pkg::arch_bits-1:0] commit_arch_0,
    input  logic [rob_pkg::arch_bits-1:0] commit_arch_1,
    input  logic [rob_pkg::data_bits-1:0] commit_value_0,
    input  logic [rob_pkg::data_bits-1:0] commit_value_1,
    input  logic [rob_pkg::data_bits-1:0] commit_pc_0,
    input  logic [rob_pkg::data_bits-1:0] commit_pc_1,
    input  logic                          commit_is_store_0,
    input  logic                          commit_is_store_1,
    output int                            mismatch_count,
    output int                            other_count,
    output int                            pending
);

    localparam int max_entries = 256;

    // expected commit stream, program order
    logic [8*16-1:0]               e_name  [max_entries];
    logic [rob_pkg::arch_bits-1:0] e_arch  [max_entries];
    logic [rob_pkg::data_bits-1:0] e_pc    [max_entries];
    logic [rob_pkg::data_bits-1:0] e_value [max_entries];
    logic                          e_store [max_entries];
    logic                          e_done  [max_entries];
    int                            e_cplt  [max_entries];   // edge that takes the completion
    int                            n_expected = 0;

    // dispatch being driven right now
    logic [8*16-1:0]               x_name = "reset";
    logic [rob_pkg::tag_bits-1:0]  x_tag;
    logic [rob_pkg::phys_bits-1:0] x_phys;
    logic                          x_store;

    int cycle, n_dispatched, n_committed, n_mismatch, n_other;
    int last_edge, last_slot;   // retire edge and slot of the previous entry

    assign mismatch_count = n_mismatch;
    assign other_count    = n_other;
    assign pending        = n_expected - n_committed;

    task automatic expect_dispatch(input logic [8*16-1:0] name,
                                   input logic [rob_pkg::tag_bits-1:0] tag,
                                   input logic [rob_pkg::phys_bits-1:0] phys,
                                   input logic [rob_pkg::arch_bits-1:0] arch,
                                   input logic [rob_pkg::data_bits-1:0] pc,
                                   input logic is_store);
        e_name[n_expected]  = name;
        e_arch[n_expected]  = arch;
        e_pc[n_expected]    = pc;
        e_store[n_expected] = is_store;
        e_done[n_expected]  = 1'b0;
        n_expected++;
        x_name  = name;
        x_tag   = tag;
        x_phys  = phys;
        x_store = is_store;
    endtask

    task automatic expect_value(input int idx, input logic [rob_pkg::data_bits-1:0] value);
        e_value[idx] = value;
        e_done[idx]  = 1'b1;
        e_cplt[idx]  = cycle + 1;   // strobe taken at the next edge
    endtask

    function automatic void compare(input logic [8*16-1:0] name, input string what,
                                    input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %0s %0s expected %0h actual %0h", name, what, expected, actual);
            n_mismatch++;
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // one commit slot against the next expected entry
    ////////////////////////////////////////////////////////////
    task automatic check_commit(input int slot, input logic [rob_pkg::arch_bits-1:0] arch,
                                input logic [31:0] value, input logic [31:0] pc,
                                input logic is_store);
        int k;
        int exp_edge;
        int exp_slot;
        k = n_committed;
        if (k >= n_expected) begin
            $display("commit in slot %0d at cycle %0d with nothing left to commit", slot, cycle);
            n_other++;
        end else if (!e_done[k]) begin
            $display("%0s: instruction %0d committed before it completed", e_name[k], k);
            n_other++;
            n_committed++;
        end else begin
            // one edge past completion, never ahead of the older entry
            exp_edge = e_cplt[k] + 1;
            if (last_slot == 0 && exp_edge < last_edge) exp_edge = last_edge;
            if (last_slot == 1 && exp_edge <= last_edge) exp_edge = last_edge + 1;
            exp_slot = (exp_edge == last_edge) ? 1 : 0;
            compare(e_name[k], "commit arch", 32'(e_arch[k]), 32'(arch));
            compare(e_name[k], "commit value", e_value[k], value);
            compare(e_name[k], "commit pc", e_pc[k], pc);
            compare(e_name[k], "commit store flag", 32'(e_store[k]), 32'(is_store));
            compare(e_name[k], "commit cycle", exp_edge, cycle);
            compare(e_name[k], "commit slot", exp_slot, slot);
            last_edge = exp_edge;
            last_slot = exp_slot;
            n_committed++;
        end
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            cycle        = 0;
            n_dispatched = 0;
        end else begin
            cycle++;
            if (dispatch_valid) n_dispatched++;
        end
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (!rstn) begin
            n_mismatch  = 0;
            n_other     = 0;
            n_committed = 0;
            last_edge   = -1;
            last_slot   = 1;
        end else begin
            if (commit_valid_1 && !commit_valid_0) begin
                $display("commit slot 1 valid without slot 0 at cycle %0d", cycle);
                n_other++;
            end
            if (commit_valid_0) begin
                check_commit(0, commit_arch_0, commit_value_0, commit_pc_0, commit_is_store_0);
            end
            if (commit_valid_1) begin
                check_commit(1, commit_arch_1, commit_value_1, commit_pc_1, commit_is_store_1);
            end
            if (dispatch_valid) begin
                compare(x_name, "dispatch tag", 32'(x_tag), 32'(dispatch_tag));
                if (!x_store) begin
                    compare(x_name, "dispatch phys", 32'(x_phys), 32'(dispatch_phys_dest));
                end
            end
            compare(x_name, "stall",
                    32'(n_dispatched - n_committed == rob_pkg::rob_depth), 32'(stall));
        end
    end

endmodule

// File: testbench/rob_tb.sv
/*
 * rob_tb
 * testbench for the retirement back end. reads the command file, models
 * the tags and the rename free list, and drives the DUT while rob_checker
 * compares its outputs
 */

`timescale 1ns/100ps

module rob_tb;

    localparam int max_lines = 64;

    logic                          clk;
    logic                          rstn;
    logic                          dispatch_valid;
    logic [rob_pkg::arch_bits-1:0] dispatch_arch_dest;
    logic [rob_pkg::data_bits-1:0] dispatch_pc;
    logic                          dispatch_is_store;
    logic [rob_pkg::tag_bits-1:0]  dispatch_tag;
    logic [rob_pkg::phys_bits-1:0] dispatch_phys_dest;
    logic                          stall;
    logic                          complete_valid_0, complete_valid_1;
    logic [rob_pkg::tag_bits-1:0]  complete_tag_0, complete_tag_1;
    logic [rob_pkg::data_bits-1:0] complete_data_0, complete_data_1;
    logic                          commit_valid_0, commit_valid_1;
    logic [rob_pkg::arch_bits-1:0] commit_arch_0, commit_arch_1;
    logic [rob_pkg::data_bits-1:0] commit_value_0, commit_value_1;
    logic [rob_pkg::data_bits-1:0] commit_pc_0, commit_pc_1;
    logic                          commit_is_store_0, commit_is_store_1;
    int                            mismatch_count, other_count, pending;

    // command file contents
    logic [8*16-1:0] t_name [max_lines];
    logic [7:0]      t_cmd  [max_lines];
    logic [31:0]     t_a    [max_lines];
    logic [31:0]     t_b    [max_lines];
    logic [31:0]     t_c    [max_lines];
    logic [31:0]     t_d    [max_lines];
    int              n_lines;
    int              setup_errors;
    logic            tests_loaded;

    // reference for tags and renaming
    int                            disp_idx;
    logic [rob_pkg::phys_bits-1:0] map_model [rob_pkg::num_arch];
    logic [rob_pkg::phys_bits-1:0] free_q [$];

    rob_top     UUT (.*);
    rob_checker chk (.*);

    always #50 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #5;
        dispatch_valid   = 1'b0;
        complete_valid_0 = 1'b0;
        complete_valid_1 = 1'b0;
    endtask

    task automatic load_tests();
        int              fd;
        int              n;
        string           line;
        logic [8*16-1:0] nm;
        logic [7:0]      cm;
        logic [31:0]     a, b, c, d;
        fd = $fopen("rob_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open rob_tests.txt");
            setup_errors++;
            return;
        end
        while (n_lines < max_lines) begin
            n = $fgets(line, fd);
            if (n == 0) break;
            if (n < 2 || line[0] == "#") continue;   // blank or column notes
            n = $sscanf(line, "%s %s %h %h %h %h", nm, cm, a, b, c, d);
            if (n != 6) begin
                $display("malformed command after line %0d of rob_tests.txt", n_lines);
                setup_errors++;
            end else begin
                t_name[n_lines] = nm;
                t_cmd[n_lines]  = cm;
                t_a[n_lines]    = a;
                t_b[n_lines]    = b;
                t_c[n_lines]    = c;
                t_d[n_lines]    = d;
                n_lines++;
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    task automatic dispatch_one(input logic [8*16-1:0] name, input logic [31:0] arch,
                                input logic [31:0] pc, input logic is_store);
        logic [rob_pkg::arch_bits-1:0] dest;
        logic [rob_pkg::phys_bits-1:0] phys;
        dest = arch[rob_pkg::arch_bits-1:0];
        phys = '0;
        if (!is_store) begin
            phys = free_q.pop_front();
            free_q.push_back(map_model[dest]);   // returns in program order
            map_model[dest] = phys;
        end
        chk.expect_dispatch(name, rob_pkg::tag_bits'(disp_idx % rob_pkg::rob_depth),
                            phys, dest, pc, is_store);
        dispatch_valid     = 1'b1;
        dispatch_arch_dest = dest;
        dispatch_pc        = pc;
        dispatch_is_store  = is_store;
        disp_idx++;
        next_cycle();
    endtask

    task automatic complete_one(input logic [31:0] port, input logic [31:0] idx,
                                input logic [31:0] data);
        logic [rob_pkg::tag_bits-1:0] tag;
        tag = rob_pkg::tag_bits'(idx % rob_pkg::rob_depth);
        chk.expect_value(int'(idx), data);
        if (port[0]) begin
            complete_valid_1 = 1'b1;
            complete_tag_1   = tag;
            complete_data_1  = data;
        end else begin
            complete_valid_0 = 1'b1;
            complete_tag_0   = tag;
            complete_data_0  = data;
        end
        next_cycle();
    endtask

    task automatic run_command(input int i);
        case (t_cmd[i])
            "D": begin
                for (int k = 0; k < int'(t_d[i]); k++) begin
                    dispatch_one(t_name[i], t_a[i] + k, t_b[i] + 32'(4 * k), t_c[i][0]);
                end
            end
            "C": begin
                for (int k = 0; k < int'(t_d[i]); k++) begin
                    complete_one(t_a[i], t_b[i] + k, t_c[i] + k);
                end
            end
            "W": repeat (t_a[i]) next_cycle();
            default: begin
                $display("unknown command in line %0d of rob_tests.txt", i);
                setup_errors++;
            end
        endcase
    endtask

    task automatic finish_run();
        int others;
        others = other_count + setup_errors;
        $display("errors: %0d mismatches, %0d other", mismatch_count, others);
        if (mismatch_count == 0 && others == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    initial begin
        clk                = 1'b0;
        rstn               = 1'b0;
        dispatch_valid     = 1'b0;
        dispatch_arch_dest = '0;
        dispatch_pc        = '0;
        dispatch_is_store  = 1'b0;
        complete_valid_0   = 1'b0;
        complete_valid_1   = 1'b0;
        complete_tag_0     = '0;
        complete_tag_1     = '0;
        complete_data_0    = '0;
        complete_data_1    = '0;
        n_lines            = 0;
        setup_errors       = 0;
        disp_idx           = 0;
        tests_loaded       = 1'b0;
        for (int r = 0; r < rob_pkg::num_arch; r++) begin
            map_model[r] = rob_pkg::phys_bits'(r);   // identity after reset
        end
        for (int p = rob_pkg::num_arch; p < rob_pkg::num_phys; p++) begin
            free_q.push_back(rob_pkg::phys_bits'(p));
        end
        load_tests();
        tests_loaded = 1'b1;
        repeat (10) @(posedge clk);
        #5;
        rstn = 1'b1;
        for (int i = 0; i < n_lines; i++) begin
            run_command(i);
        end
        while (pending != 0) @(negedge clk);   // outstanding commits
        @(negedge clk);
        finish_run();
    end

    // watchdog, sized from the number of commands
    initial begin
        int limit;
        wait (tests_loaded === 1'b1);
        limit = 20 * n_lines + 200;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles with %0d commits outstanding", limit, pending);
        $display("errors: %0d mismatches, %0d other", mismatch_count,
                 other_count + setup_errors + 1);
        $display("tests failed");
        $finish;
    end

endmodule

// File: rob_tests.txt
# name  cmd  a  b  c  d   all numbers hex
# D: a=arch b=pc c=store d=count, arch +1 and pc +4 per instruction
# C: a=port b=first dispatch index c=data d=count, index and data +1 each; W: a=cycles
idle   W  5   0    0         0
rev    D  1   100  0         4
rev    C  0   3    a0000003  1
rev    C  1   2    a0000002  1
rev    C  0   1    a0000001  1
rev    C  1   0    a0000000  1
pair   D  5   200  0         2
pair   C  0   4    b0000004  2
store  D  0   300  1         1
store  D  6   304  0         1
store  C  1   6    c0000006  2
drain  W  6   0    0         0
full   D  8   400  0         10
full   C  1   8    d0000008  4
full   W  3   0    0         0
full   D  9   500  0         1
full   C  0   c    d000000c  d
reuse  D  10  600  0         c
reuse  C  1   19   e0000019  c
reuse  W  a   0    0         0

// File: project.f
source/rob_pkg.sv
source/rename_map.sv
source/reorder_buffer.sv
source/retire_unit.sv
source/rob_top.sv
testbench/rob_checker.sv
testbench/rob_tb.sv

// File: Makefile
# Verilator build and run of rob_tb, result read back from the log

sim:
	verilator --binary --timing -f project.f --top-module rob_tb -o rob_sim
	./obj_dir/rob_sim | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
